/* common/dma_dist_defs.svh */
/*
 * DMA distribution stage parameters
 * Port count, region geometry, L1 window bounds and credit depths
 */
`ifndef DMA_DIST_DEFS_SVH
`define DMA_DIST_DEFS_SVH

// Backend ports and the bytes each one covers in the L1 window
`define DMA_NUM_PORTS    4
`define DMA_REGION_BYTES 256
`define DMA_WINDOW_BYTES (`DMA_REGION_BYTES * `DMA_NUM_PORTS)

`define DMA_ADDR_W 32

// Distributed L1 window, end is exclusive
`define DMA_L1_START 32'h1000_0000
`define DMA_L1_END   32'h1010_0000

// Credits and queue depths
`define DMA_REQ_CREDITS 4
`define DMA_BE_CREDITS  2
`define DMA_MASK_DEPTH  4

`endif

/* common/dma_dist_pkg.sv */
/*
 * DMA distribution package
 * Burst request, distribution mode and port mask types
 */
`default_nettype none

`include "dma_dist_defs.svh"

package dma_dist_pkg;

  // Split sends each port its own region share, dup copies to every port
  typedef enum logic {
    DIST_SPLIT = 1'b0,
    DIST_DUP   = 1'b1
  } dist_mode_e;

  typedef logic [`DMA_ADDR_W-1:0] addr_t;

  // One-dimensional burst, also used for the per-port slices
  typedef struct packed {
    addr_t      src;
    addr_t      dst;
    addr_t      num_bytes;
    dist_mode_e mode;
  } burst_req_t;

  // One bit per backend port
  typedef logic [`DMA_NUM_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

/* dist_midend/dma_completion_merge.sv */
/*
 * Completion merge
 * Matches per-port completions against queued request masks and
 * emits one in-order done per request, plus the idle status
 */
`timescale 1ns/10ps
`default_nettype none

`include "dma_dist_defs.svh"

module dma_completion_merge (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      mask_valid_i,
  output logic                      mask_ready_o,
  input  dma_dist_pkg::port_mask_t  mask_i,
  input  logic [`DMA_NUM_PORTS-1:0] be_done_i,
  input  logic [`DMA_NUM_PORTS-1:0] be_idle_i,
  input  logic                      intake_empty_i,
  output logic                      done_o,
  output logic                      idle_o
);

  // Done can lead its mask by the one request still in issue
  localparam int unsigned CNT_W = $clog2(`DMA_MASK_DEPTH + 2) + 1;

  dma_dist_pkg::port_mask_t  head_mask;
  logic                      head_ready, head_pop;
  logic                      mask_full, mask_empty;
  logic [CNT_W-1:0]          done_cnt_q [`DMA_NUM_PORTS];
  logic [`DMA_NUM_PORTS-1:0] port_ok;

  dma_credit_queue #(
    .payload_t (dma_dist_pkg::port_mask_t),
    .DEPTH     (`DMA_MASK_DEPTH)
  ) i_mask_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (mask_valid_i),
    .data_i  (mask_i),
    .valid_o (),
    .ready_i (head_ready),
    .data_o  (head_mask),
    .pop_o   (head_pop),
    .empty_o (mask_empty),
    .full_o  (mask_full)
  );

  assign mask_ready_o = !mask_full;

  // A port is satisfied if uninvolved or holding an unused completion
  always_comb begin
    for (int unsigned i = 0; i < `DMA_NUM_PORTS; i++) begin
      port_ok[i] = !head_mask[i] || (done_cnt_q[i] != '0);
    end
  end

  assign head_ready = &port_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < `DMA_NUM_PORTS; i++) begin
        done_cnt_q[i] <= '0;
      end
      done_o <= 1'b0;
      idle_o <= 1'b0;
    end else begin
      for (int unsigned i = 0; i < `DMA_NUM_PORTS; i++) begin
        done_cnt_q[i] <= done_cnt_q[i] + CNT_W'(be_done_i[i])
                         - CNT_W'(head_pop && head_mask[i]);
      end
      done_o <= head_pop;
      idle_o <= (&be_idle_i) && mask_empty && intake_empty_i;
    end
  end

endmodule

`default_nettype wire

/* dist_midend/dma_port_issue.sv */
/*
 * Port issue
 * Per-port credit counters, issues each involved slice once and
 * hands the request mask to completion merge on retirement
 */
`timescale 1ns/10ps
`default_nettype none

`include "dma_dist_defs.svh"

module dma_port_issue (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          slice_valid_i,
  output logic                                          slice_ready_o,
  input  dma_dist_pkg::burst_req_t [`DMA_NUM_PORTS-1:0] slice_i,
  input  dma_dist_pkg::port_mask_t                      mask_i,
  output dma_dist_pkg::burst_req_t [`DMA_NUM_PORTS-1:0] be_req_o,
  output logic [`DMA_NUM_PORTS-1:0]                     be_valid_o,
  input  logic [`DMA_NUM_PORTS-1:0]                     be_credit_i,
  output logic                                          mask_valid_o,
  input  logic                                          mask_ready_i,
  output dma_dist_pkg::port_mask_t                      mask_o
);

  localparam int unsigned CRD_W = $clog2(`DMA_BE_CREDITS + 1);

  logic [CRD_W-1:0]                  credit_q [`DMA_NUM_PORTS];
  logic [`DMA_NUM_PORTS-1:0]         has_credit;
  dma_dist_pkg::port_mask_t          pend_q, pend_rest;
  logic                              busy_q;
  logic                              accept, retire;

  always_comb begin
    for (int unsigned i = 0; i < `DMA_NUM_PORTS; i++) begin
      has_credit[i] = (credit_q[i] != '0);
    end
  end

  // Ports run independently
  assign be_valid_o = pend_q & has_credit;
  assign pend_rest  = pend_q & ~be_valid_o;

  // Retire once the last involved port is out, or at once with none
  assign mask_valid_o  = busy_q && (pend_rest == '0);
  assign retire        = mask_valid_o && mask_ready_i;
  assign slice_ready_o = !busy_q || retire;
  assign accept        = slice_valid_i && slice_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      pend_q <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      pend_q <= mask_i;
    end else begin
      if (retire) begin
        busy_q <= 1'b0;
      end
      pend_q <= pend_rest;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < `DMA_NUM_PORTS; i++) begin
        credit_q[i] <= CRD_W'(`DMA_BE_CREDITS);
      end
    end else begin
      for (int unsigned i = 0; i < `DMA_NUM_PORTS; i++) begin
        credit_q[i] <= credit_q[i] + CRD_W'(be_credit_i[i]) - CRD_W'(be_valid_o[i]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      be_req_o <= slice_i;
      mask_o   <= mask_i;
    end
  end

endmodule

`default_nettype wire

/* dist_midend/dma_slice_calc.sv */
/*
 * Slice calculation
 * Cuts one burst into per-port slices of the interleaved L1 window
 * and registers the slice set with its involved-port mask
 */
`timescale 1ns/10ps
`default_nettype none

`include "dma_dist_defs.svh"

module dma_slice_calc (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          req_valid_i,
  output logic                                          req_ready_o,
  input  dma_dist_pkg::burst_req_t                      req_i,
  output logic                                          slice_valid_o,
  input  logic                                          slice_ready_i,
  output dma_dist_pkg::burst_req_t [`DMA_NUM_PORTS-1:0] slice_o,
  output dma_dist_pkg::port_mask_t                      mask_o
);

  localparam int unsigned OFF_W = $clog2(`DMA_WINDOW_BYTES);
  localparam dma_dist_pkg::addr_t REGION = dma_dist_pkg::addr_t'(`DMA_REGION_BYTES);

  dma_dist_pkg::addr_t anchor, off, span_end;
  dma_dist_pkg::addr_t reg_lo [`DMA_NUM_PORTS];
  dma_dist_pkg::addr_t reg_hi [`DMA_NUM_PORTS];
  dma_dist_pkg::addr_t beg    [`DMA_NUM_PORTS];
  dma_dist_pkg::addr_t fin    [`DMA_NUM_PORTS];
  dma_dist_pkg::burst_req_t [`DMA_NUM_PORTS-1:0] slice_d;
  dma_dist_pkg::port_mask_t mask_d;
  logic src_in_l1;
  logic accept;
  logic valid_q;

  // Anchor on whichever side of the copy sits in L1
  assign src_in_l1 = (req_i.src >= `DMA_L1_START) && (req_i.src < `DMA_L1_END);
  assign anchor    = src_in_l1 ? req_i.src : req_i.dst;
  assign off       = dma_dist_pkg::addr_t'(anchor[OFF_W-1:0]);
  assign span_end  = off + req_i.num_bytes;

  always_comb begin
    for (int unsigned i = 0; i < `DMA_NUM_PORTS; i++) begin
      reg_lo[i]  = dma_dist_pkg::addr_t'(i * `DMA_REGION_BYTES);
      reg_hi[i]  = dma_dist_pkg::addr_t'((i + 1) * `DMA_REGION_BYTES);
      beg[i]     = (off > reg_lo[i]) ? off : reg_lo[i];
      fin[i]     = (span_end < reg_hi[i]) ? span_end : reg_hi[i];
      slice_d[i] = req_i;
      if (req_i.mode == dma_dist_pkg::DIST_DUP) begin
        // Same source, placed at the matching offset of each region
        mask_d[i]            = 1'b1;
        slice_d[i].dst       = req_i.dst + reg_lo[i];
        slice_d[i].num_bytes = (req_i.num_bytes < REGION) ? req_i.num_bytes : REGION;
      end else begin
        mask_d[i] = (reg_lo[i] < span_end) && (reg_hi[i] > off);
        if (mask_d[i]) begin
          slice_d[i].src       = req_i.src + (beg[i] - off);
          slice_d[i].dst       = req_i.dst + (beg[i] - off);
          slice_d[i].num_bytes = fin[i] - beg[i];
        end else begin
          // Never issued, kept empty
          slice_d[i].num_bytes = '0;
        end
      end
    end
  end

  // Take a new request when empty or when the held set leaves this cycle
  assign req_ready_o   = !valid_q || slice_ready_i;
  assign accept        = req_valid_i && req_ready_o;
  assign slice_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (slice_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slice_o <= slice_d;
      mask_o  <= mask_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/dma_credit_queue.sv */
/*
 * Credit queue
 * Circular FIFO with a generic payload type, pop_o flags each output handshake
 */
`timescale 1ns/10ps
`default_nettype none

module dma_credit_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o,
  output logic     pop_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign valid_o = !empty_o;
  assign pop_o   = valid_o && ready_i;
  assign data_o  = mem_q[rd_ptr_q];

  // Upstream credits keep pushes off a full queue
  assign do_push = push_i && !full_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_o) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(pop_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/dma_dist_top.sv */
/*
 * DMA distribution stage top
 * Intake queue, slice calculation, port issue and completion merge
 */
`timescale 1ns/10ps
`default_nettype none

`include "dma_dist_defs.svh"

module dma_dist_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  dma_dist_pkg::burst_req_t                      req_i,
  input  logic                                          req_valid_i,
  output logic                                          req_credit_o,
  output dma_dist_pkg::burst_req_t [`DMA_NUM_PORTS-1:0] be_req_o,
  output logic [`DMA_NUM_PORTS-1:0]                     be_valid_o,
  input  logic [`DMA_NUM_PORTS-1:0]                     be_credit_i,
  input  logic [`DMA_NUM_PORTS-1:0]                     be_done_i,
  input  logic [`DMA_NUM_PORTS-1:0]                     be_idle_i,
  output logic                                          done_o,
  output logic                                          idle_o
);

  dma_dist_pkg::burst_req_t                      intake_req;
  logic                                          intake_valid, intake_ready;
  logic                                          intake_empty;
  dma_dist_pkg::burst_req_t [`DMA_NUM_PORTS-1:0] slices;
  dma_dist_pkg::port_mask_t                      slice_mask, issue_mask;
  logic                                          slice_valid, slice_ready;
  logic                                          mask_valid, mask_ready;

  // Each pop returns one credit upstream
  dma_credit_queue #(
    .payload_t (dma_dist_pkg::burst_req_t),
    .DEPTH     (`DMA_REQ_CREDITS)
  ) i_intake_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_valid_i),
    .data_i  (req_i),
    .valid_o (intake_valid),
    .ready_i (intake_ready),
    .data_o  (intake_req),
    .pop_o   (req_credit_o),
    .empty_o (intake_empty),
    .full_o  ()
  );

  dma_slice_calc i_slice_calc (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (intake_valid),
    .req_ready_o   (intake_ready),
    .req_i         (intake_req),
    .slice_valid_o (slice_valid),
    .slice_ready_i (slice_ready),
    .slice_o       (slices),
    .mask_o        (slice_mask)
  );

  dma_port_issue i_port_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slice_valid_i (slice_valid),
    .slice_ready_o (slice_ready),
    .slice_i       (slices),
    .mask_i        (slice_mask),
    .be_req_o      (be_req_o),
    .be_valid_o    (be_valid_o),
    .be_credit_i   (be_credit_i),
    .mask_valid_o  (mask_valid),
    .mask_ready_i  (mask_ready),
    .mask_o        (issue_mask)
  );

  dma_completion_merge i_completion_merge (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mask_valid_i   (mask_valid),
    .mask_ready_o   (mask_ready),
    .mask_i         (issue_mask),
    .be_done_i      (be_done_i),
    .be_idle_i      (be_idle_i),
    .intake_empty_i (intake_empty),
    .done_o         (done_o),
    .idle_o         (idle_o)
  );

endmodule

`default_nettype wire

/* verif/dma_dist_tb.sv */
/*
 * Testbench for the DMA distribution stage
 * Directed split, duplicate and credit tests against a backend model
 */
`timescale 1ns/10ps
`default_nettype none

`include "dma_dist_defs.svh"

module dma_dist_tb;

  localparam int NP         = `DMA_NUM_PORTS;
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 5;
  localparam int NUM_REQS   = 15;

  logic                              clk_i = 1'b0;
  logic                              rst_ni;
  dma_dist_pkg::burst_req_t          req_i;
  logic                              req_valid_i;
  logic                              req_credit_o;
  dma_dist_pkg::burst_req_t [NP-1:0] be_req_o;
  logic [NP-1:0]                     be_valid_o, be_credit_i, be_done_i, be_idle_i;
  logic                              done_o, idle_o;

  // Expected slices per port, and per-port done counts each request needs
  dma_dist_pkg::burst_req_t exp_q [NP][$];
  int                       need_q [NP][$];
  dma_dist_pkg::port_mask_t mask_q [$];
  int    outstanding [NP];
  int    timer [NP];
  int    recv_cnt [NP];
  int    done_issued [NP];
  int    used_cnt [NP];
  int    up_credits, credit_pulses, sent, done_cnt;
  int    errors = 0;
  int    checks = 0;
  logic  hold;
  string test_name;

  dma_dist_top dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_credit_o (req_credit_o),
    .be_req_o     (be_req_o),
    .be_valid_o   (be_valid_o),
    .be_credit_i  (be_credit_i),
    .be_done_i    (be_done_i),
    .be_idle_i    (be_idle_i),
    .done_o       (done_o),
    .idle_o       (idle_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  // Slice rule worked out for one port
  function automatic dma_dist_pkg::burst_req_t ref_slice(
    input dma_dist_pkg::burst_req_t r, input int p, output logic used);
    dma_dist_pkg::burst_req_t s;
    longint anchor, off, span_end, lo, hi, b, f;
    s        = r;
    anchor   = (r.src >= `DMA_L1_START && r.src < `DMA_L1_END) ? r.src : r.dst;
    off      = anchor % `DMA_WINDOW_BYTES;
    span_end = off + r.num_bytes;
    lo       = p * `DMA_REGION_BYTES;
    hi       = lo + `DMA_REGION_BYTES;
    if (r.mode == dma_dist_pkg::DIST_DUP) begin
      used        = 1'b1;
      s.dst       = r.dst + dma_dist_pkg::addr_t'(lo);
      s.num_bytes = (r.num_bytes < `DMA_REGION_BYTES) ? r.num_bytes : `DMA_REGION_BYTES;
    end else begin
      used = (lo < span_end) && (hi > off);
      b    = (off > lo) ? off : lo;
      f    = (span_end < hi) ? span_end : hi;
      if (used) begin
        s.src       = r.src + dma_dist_pkg::addr_t'(b - off);
        s.dst       = r.dst + dma_dist_pkg::addr_t'(b - off);
        s.num_bytes = dma_dist_pkg::addr_t'(f - b);
      end
    end
    return s;
  endfunction

  task automatic send_req(input logic [31:0] src, input logic [31:0] dst,
                          input logic [31:0] len, input dma_dist_pkg::dist_mode_e mode);
    dma_dist_pkg::burst_req_t r;
    dma_dist_pkg::burst_req_t s;
    dma_dist_pkg::port_mask_t mask;
    logic used;
    r = '{src: src, dst: dst, num_bytes: len, mode: mode};
    for (int p = 0; p < NP; p++) begin
      s = ref_slice(r, p, used);
      mask[p] = used;
      if (used) begin
        exp_q[p].push_back(s);
        used_cnt[p]++;
        need_q[p].push_back(used_cnt[p]);
      end
    end
    mask_q.push_back(mask);
    // Upstream may only send while holding a credit
    while (up_credits == 0) begin
      @(posedge clk_i);
      #1;
    end
    up_credits--;
    sent++;
    req_i       = r;
    req_valid_i = 1'b1;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  function automatic bit drained();
    bit ok;
    ok = (done_cnt == sent);
    for (int p = 0; p < NP; p++) begin
      ok = ok && (exp_q[p].size() == 0);
    end
    return ok;
  endfunction

  task automatic wait_drain();
    while (!drained()) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Backend model, each port completes its slices in order after a short random delay
  always @(posedge clk_i) begin
    #1;
    for (int p = 0; p < NP; p++) begin
      be_credit_i[p] = 1'b0;
      be_done_i[p]   = 1'b0;
      if (outstanding[p] > 0 && !hold) begin
        if (timer[p] == 0) begin
          be_credit_i[p] = 1'b1;
          be_done_i[p]   = 1'b1;
          outstanding[p]--;
          done_issued[p]++;
          timer[p] = $urandom_range(3, 0);
        end else begin
          timer[p]--;
        end
      end
      be_idle_i[p] = (outstanding[p] == 0);
    end
  end

  // Outputs sampled mid-cycle
  always @(negedge clk_i) begin : monitor
    dma_dist_pkg::port_mask_t head;
    if (req_credit_o) begin
      up_credits++;
      credit_pulses++;
    end
    for (int p = 0; p < NP; p++) begin
      if (be_valid_o[p]) begin
        outstanding[p]++;
        recv_cnt[p]++;
        check($sformatf("port %0d credit limit", p), 1, outstanding[p] <= `DMA_BE_CREDITS);
        if (exp_q[p].size() == 0) begin
          errors++;
          $display("error %s: port %0d received a slice it should not get", test_name, p);
        end else begin
          check($sformatf("port %0d slice", p), exp_q[p].pop_front(), be_req_o[p]);
        end
      end
    end
    if (done_o) begin
      done_cnt++;
      if (mask_q.size() == 0) begin
        errors++;
        $display("error %s: done pulse with no request outstanding", test_name);
      end else begin
        head = mask_q.pop_front();
        for (int p = 0; p < NP; p++) begin
          if (head[p]) begin
            check($sformatf("done after port %0d", p), 1,
                  done_issued[p] >= need_q[p].pop_front());
          end
        end
      end
    end
  end

  task automatic test_reset();
    test_name = "reset";
    repeat (2) @(posedge clk_i);
    #1;
    check("be_valid_o", 0, be_valid_o);
    check("done_o", 0, done_o);
    check("idle_o", 1, idle_o);
  endtask

  task automatic test_split();
    test_name = "split";
    // Anchor in src, spans of one, two and four regions
    send_req(32'h1000_0010, 32'h8000_0000, 32'h40, dma_dist_pkg::DIST_SPLIT);
    send_req(32'h1000_01F0, 32'h8000_1000, 32'h20, dma_dist_pkg::DIST_SPLIT);
    send_req(32'h1000_0400, 32'h8000_2000, 32'h400, dma_dist_pkg::DIST_SPLIT);
    // Anchor in dst
    send_req(32'h2000_0000, 32'h1000_0320, 32'h80, dma_dist_pkg::DIST_SPLIT);
    send_req(32'h2000_0100, 32'h1000_0080, 32'h100, dma_dist_pkg::DIST_SPLIT);
    send_req(32'h2000_0000, 32'h1000_0C08, 32'h3F0, dma_dist_pkg::DIST_SPLIT);
    wait_drain();
  endtask

  task automatic test_dup();
    test_name = "duplicate";
    send_req(32'h3000_0000, 32'h1000_0010, 32'h80, dma_dist_pkg::DIST_DUP);
    send_req(32'h3000_0000, 32'h1000_0020, 32'h200, dma_dist_pkg::DIST_DUP);
    send_req(32'h3000_1000, 32'h1000_0000, 32'h100, dma_dist_pkg::DIST_DUP);
    wait_drain();
  endtask

  task automatic test_credits();
    int crd_base;
    int done_base;
    int recv_base [NP];
    test_name = "credits";
    crd_base  = credit_pulses;
    done_base = done_cnt;
    for (int p = 0; p < NP; p++) begin
      recv_base[p] = recv_cnt[p];
    end
    hold = 1'b1;
    for (int k = 0; k < 6; k++) begin
      send_req(32'h1000_0000 + 32'(k) * 32'h400, 32'h8000_0000 | ($urandom & 32'hFFF0),
               32'h400, dma_dist_pkg::DIST_SPLIT);
    end
    repeat (20) @(posedge clk_i);
    #1;
    // Backend credits, plus one request in issue and one in slice calc
    check("credits returned", `DMA_BE_CREDITS + 2, credit_pulses - crd_base);
    check("done while held", done_base, done_cnt);
    for (int p = 0; p < NP; p++) begin
      check($sformatf("port %0d slices while held", p), `DMA_BE_CREDITS,
            recv_cnt[p] - recv_base[p]);
    end
    hold = 1'b0;
    wait_drain();
  endtask

  task automatic test_idle();
    test_name = "idle";
    repeat (3) @(posedge clk_i);
    #1;
    check("idle_o", 1, idle_o);
    check("credit pulses", sent, credit_pulses);
    check("done pulses", sent, done_cnt);
  endtask

  // Watchdog sized from the request count
  initial begin
    #(CLK_PERIOD * (RST_CYCLES + 200 * NUM_REQS));
    $display("error: watchdog timeout, traffic did not drain");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    void'($urandom(2025));
    rst_ni        = 1'b0;
    req_i         = '0;
    req_valid_i   = 1'b0;
    be_credit_i   = '0;
    be_done_i     = '0;
    be_idle_i     = '1;
    hold          = 1'b0;
    up_credits    = `DMA_REQ_CREDITS;
    credit_pulses = 0;
    sent          = 0;
    done_cnt      = 0;
    for (int p = 0; p < NP; p++) begin
      outstanding[p] = 0;
      timer[p]       = 0;
      recv_cnt[p]    = 0;
      done_issued[p] = 0;
      used_cnt[p]    = 0;
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset();
    test_split();
    test_dup();
    test_credits();
    test_idle();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/dma_dist_pkg.sv
rtl/dma_credit_queue.sv
dist_midend/dma_slice_calc.sv
dist_midend/dma_port_issue.sv
dist_midend/dma_completion_merge.sv
rtl/dma_dist_top.sv
verif/dma_dist_tb.sv
